// File: dv/pwm_periph_assert.sv
`timescale 1ns/10ps

module pwm_periph_assert
(
  input logic                                aclk,
  input logic                                areset_n,
  input logic                                awready,
  input logic                                wready,
  input logic                                bvalid,
  input logic                                bready,
  input pwm_periph_pkg::axi_resp_t           bresp,
  input logic                                rvalid,
  input logic                                rready,
  input logic [pwm_periph_pkg::DATA_W-1:0]   rdata,
  input pwm_periph_pkg::axi_resp_t           rresp,
  input pwm_periph_pkg::wr_state_t           wr_state,
  input pwm_periph_pkg::rd_state_t           rd_state
);
  import pwm_periph_pkg::*;

  // Response held until taken
  assert property (@(posedge aclk) disable iff (!areset_n)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("write response dropped or changed before bready");

  assert property (@(posedge aclk) disable iff (!areset_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else $error("read response dropped or changed before rready");

  assert property (@(posedge aclk) !areset_n |=> !bvalid && !rvalid)
    else $error("response valid set right after reset");

  // No new write while a response waits
  assert property (@(posedge aclk) disable iff (!areset_n)
    bvalid |-> !awready && !wready)
    else $error("write channel ready while bvalid is high");

  // Two cycles in the pipeline before each response
  assert property (@(posedge aclk) disable iff (!areset_n)
    $rose(bvalid) |-> $past(wr_state, 2) == WR_COMMIT)
    else $error("write response raised without the two-stage commit");

  assert property (@(posedge aclk) disable iff (!areset_n)
    $rose(rvalid) |-> $past(rd_state, 2) == RD_FETCH)
    else $error("read response raised without the two-stage fetch");

endmodule

bind axil_regs pwm_periph_assert u_assert
(
  .aclk     (aclk),
  .areset_n (areset_n),
  .awready  (awready),
  .wready   (wready),
  .bvalid   (bvalid),
  .bready   (bready),
  .bresp    (bresp),
  .rvalid   (rvalid),
  .rready   (rready),
  .rdata    (rdata),
  .rresp    (rresp),
  .wr_state (wr_state),
  .rd_state (rd_state)
);

// File: dv/pwm_periph_tb.sv
`timescale 1ns/10ps

module pwm_periph_tb;
  import pwm_periph_pkg::*;

  typedef struct packed
  {
    logic              is_write;
    logic [1:0]        order;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    axi_resp_t         resp;
    logic [DATA_W-1:0] rd_exp;
  } step_t;

  logic              aclk = 1'b0;
  logic              areset_n;
  logic              awvalid, wvalid, bready, arvalid, rready;
  logic              awready, wready, bvalid, arready, rvalid, pwm_out;
  logic [ADDR_W-1:0] awaddr, araddr;
  logic [DATA_W-1:0] wdata, rdata;
  logic [STRB_W-1:0] wstrb;
  axi_resp_t         bresp, rresp;

  step_t             table_q[$];
  logic [DATA_W-1:0] model[2];
  int                errors = 0;
  int                wd_cycles = 0;
  int                pwm_p[5] = '{10, 8, 16, 20, 5};
  int                pwm_d[5] = '{4, 12, 0, 20, 1};

  pwm_periph_top #(.CNT_W(16)) UUT (.*);

  always #50 aclk = ~aclk;

  task automatic report_mismatch(input string name, input logic [DATA_W-1:0] got,
                                 input logic [DATA_W-1:0] exp);
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, got);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  // Expected values come from the register model
  task automatic add_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input logic [1:0] order);
    step_t             s;
    logic [DATA_W-1:0] mask;
    mask = '0;
    for (int b = 0; b < STRB_W; b++)
    begin
      if (strb[b])
        mask[8*b +: 8] = 8'hff;
    end
    s = '{1'b1, order, addr, data, strb, OKAY, '0};
    if (addr[1:0] != 2'b00)
      s.resp = SLVERR;
    else
      model[addr[2]] = (model[addr[2]] & ~mask) | (data & mask);
    table_q.push_back(s);
  endtask

  task automatic add_read(input logic [ADDR_W-1:0] addr);
    step_t s;
    s = '{1'b0, 2'd0, addr, '0, '0, OKAY, '0};
    if (addr[1:0] != 2'b00)
      s.resp = SLVERR;
    else
      s.rd_exp = model[addr[2]];
    table_q.push_back(s);
  endtask

  task automatic build_table();
    logic [ADDR_W-1:0] a;
    add_read(REG_PERIOD_ADDR);
    add_read(REG_DUTY_ADDR);
    add_write(REG_PERIOD_ADDR, 32'h1234_5678, 4'hf, 2'd0);
    add_write(REG_DUTY_ADDR, 32'hcafe_0042, 4'hf, 2'd1);
    add_read(REG_PERIOD_ADDR);
    add_read(REG_DUTY_ADDR);
    add_write(REG_PERIOD_ADDR, 32'ha5a5_0f0f, 4'hf, 2'd2);
    add_read(REG_PERIOD_ADDR);
    // Partial strobes
    add_write(REG_DUTY_ADDR, 32'h1122_3344, 4'b0101, 2'd0);
    add_read(REG_DUTY_ADDR);
    add_write(REG_PERIOD_ADDR, 32'hffee_ddcc, 4'b1000, 2'd2);
    add_write(REG_PERIOD_ADDR, 32'h0000_7700, 4'b0010, 2'd1);
    add_read(REG_PERIOD_ADDR);
    add_write(REG_DUTY_ADDR, 32'h5555_5555, 4'b0000, 2'd0);
    add_read(REG_DUTY_ADDR);
    // Every misaligned byte address
    for (int i = 1; i < 8; i++)
    begin
      if (i != 4)
      begin
        a = ADDR_W'(i);
        add_write(a, 32'hdead_beef, 4'hf, 2'(i % 3));
        add_read(a);
      end
    end
    add_read(REG_PERIOD_ADDR);
    add_read(REG_DUTY_ADDR);
    repeat (6)
    begin
      a = ADDR_W'($urandom_range(0, 7));
      add_write(a, $urandom, STRB_W'($urandom_range(0, 15)), 2'($urandom_range(0, 2)));
      add_read(a);
    end
  endtask

  task automatic take_bresp(input axi_resp_t exp_resp);
    int n;
    int hold;
    n = 0;
    while (!bvalid && n < 20)
    begin
      @(negedge aclk);
      n++;
    end
    if (!bvalid)
      report_problem("write response never arrived");
    hold = $urandom_range(0, 3);
    for (int i = 0; i <= hold; i++)
    begin
      if (!bvalid)
        report_mismatch("bvalid", bvalid, 1'b1);
      if (bresp !== exp_resp)
        report_mismatch("bresp", bresp, exp_resp);
      if (awready || wready)
        report_problem("write channel ready while the response is pending");
      if (i < hold)
        @(negedge aclk);
    end
    bready = 1'b1;
    @(negedge aclk);
    bready = 1'b0;
    if (bvalid)
      report_mismatch("bvalid", bvalid, 1'b0);
    if (!awready || !wready)
      report_problem("write channels not ready after the response was taken");
  endtask

  // Order 0 sends AW and W together, 1 address first, 2 data first
  task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input logic [STRB_W-1:0] strb, input logic [1:0] order,
                          input axi_resp_t exp_resp);
    logic aw_done;
    logic w_done;
    logic aw_hs;
    logic w_hs;
    aw_done = 1'b0;
    w_done = 1'b0;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = (order != 2'd2);
    wvalid = (order != 2'd1);
    while (!(aw_done && w_done))
    begin
      aw_hs = awvalid && awready;
      w_hs = wvalid && wready;
      @(negedge aclk);
      if (aw_hs)
      begin
        awvalid = 1'b0;
        aw_done = 1'b1;
      end
      if (w_hs)
      begin
        wvalid = 1'b0;
        w_done = 1'b1;
      end
      awvalid = awvalid || (w_done && !aw_done);
      wvalid = wvalid || (aw_done && !w_done);
    end
    take_bresp(exp_resp);
  endtask

  task automatic do_read(input logic [ADDR_W-1:0] addr, input axi_resp_t exp_resp,
                         input logic [DATA_W-1:0] exp_data);
    int n;
    int hold;
    araddr = addr;
    arvalid = 1'b1;
    while (!arready)
      @(negedge aclk);
    @(negedge aclk);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid && n < 20)
    begin
      @(negedge aclk);
      n++;
    end
    if (!rvalid)
      report_problem("read response never arrived");
    hold = $urandom_range(0, 3);
    for (int i = 0; i <= hold; i++)
    begin
      if (!rvalid)
        report_mismatch("rvalid", rvalid, 1'b1);
      if (rresp !== exp_resp)
        report_mismatch("rresp", rresp, exp_resp);
      if (rdata !== exp_data)
        report_mismatch("rdata", rdata, exp_data);
      if (i < hold)
        @(negedge aclk);
    end
    rready = 1'b1;
    @(negedge aclk);
    rready = 1'b0;
    if (rvalid)
      report_mismatch("rvalid", rvalid, 1'b0);
    if (!arready)
      report_problem("read address channel not ready after the response was taken");
  endtask

  // Settle for two periods, then count high cycles over one period
  task automatic measure_pwm(input int p, input int d);
    int high_cnt;
    int exp_cnt;
    do_write(REG_PERIOD_ADDR, p, 4'hf, 2'd0, OKAY);
    do_write(REG_DUTY_ADDR, d, 4'hf, 2'd0, OKAY);
    repeat (2 * p)
      @(negedge aclk);
    high_cnt = 0;
    repeat (p)
    begin
      if (pwm_out)
        high_cnt++;
      @(negedge aclk);
    end
    exp_cnt = (d < p) ? d : p;
    if (high_cnt != exp_cnt)
      report_mismatch("pwm_out high count", high_cnt, exp_cnt);
  endtask

  initial
  begin
    void'($urandom(32'hc4b30dfe));
    areset_n = 1'b0;
    awvalid = 1'b0;
    awaddr = '0;
    wvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    bready = 1'b0;
    arvalid = 1'b0;
    araddr = '0;
    rready = 1'b0;
    model[0] = '0;
    model[1] = '0;
    build_table();
    wd_cycles = table_q.size() * 40;
    foreach (pwm_p[i])
      wd_cycles += 3 * pwm_p[i] + 80;
    repeat (2)
      @(negedge aclk);
    areset_n = 1'b1;
    if (!awready || !wready || !arready)
      report_problem("AXI ready signals not high after reset");
    if (bvalid || rvalid)
      report_problem("response valid high after reset");
    foreach (table_q[i])
    begin
      repeat ($urandom_range(0, 3))
        @(negedge aclk);
      if (table_q[i].is_write)
        do_write(table_q[i].addr, table_q[i].data, table_q[i].strb, table_q[i].order,
                 table_q[i].resp);
      else
        do_read(table_q[i].addr, table_q[i].resp, table_q[i].rd_exp);
    end
    foreach (pwm_p[i])
      measure_pwm(pwm_p[i], pwm_d[i]);
    $display("Checks finished with %0d errors", errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    wait (wd_cycles > 0);
    repeat (wd_cycles)
      @(posedge aclk);
    $display("Timeout after %0d cycles with the tests still running", wd_cycles);
    $display("Test failures found");
    $finish;
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the PWM peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module pwm_periph_tb \
  -o pwm_periph_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/pwm_periph_sim > sim.log 2>&1 || { cat sim.log; echo "Simulation aborted"; exit 1; }
cat sim.log

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"

// File: source/axil_regs.sv
`timescale 1ns/10ps

module axil_regs
(
  input  logic                                aclk,
  input  logic                                areset_n,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [pwm_periph_pkg::ADDR_W-1:0]   awaddr,
  input  logic                                wvalid,
  output logic                                wready,
  input  logic [pwm_periph_pkg::DATA_W-1:0]   wdata,
  input  logic [pwm_periph_pkg::STRB_W-1:0]   wstrb,
  output logic                                bvalid,
  input  logic                                bready,
  output pwm_periph_pkg::axi_resp_t           bresp,
  input  logic                                arvalid,
  output logic                                arready,
  input  logic [pwm_periph_pkg::ADDR_W-1:0]   araddr,
  output logic                                rvalid,
  input  logic                                rready,
  output logic [pwm_periph_pkg::DATA_W-1:0]   rdata,
  output pwm_periph_pkg::axi_resp_t           rresp,
  output pwm_periph_pkg::pwm_cfg_t            cfg
);
  import pwm_periph_pkg::*;

  wr_state_t         wr_state;
  logic              aw_set;
  logic              w_set;
  logic              wr_go;
  logic              wr_req;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  logic              wr_req_d0;
  logic [ADDR_W-1:0] wr_adr_d0;
  logic [DATA_W-1:0] wr_dat_d0;
  logic [STRB_W-1:0] wr_strb_d0;
  logic              wr_aligned;
  axi_resp_t         wr_resp;

  rd_state_t         rd_state;
  logic              rd_req;
  logic              rd_ack;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_sel;
  logic [DATA_W-1:0] rd_dat_q;
  axi_resp_t         rd_resp_q;

  pwm_cfg_t          regs_q;

  // Replace only the bytes enabled by the strobe
  function automatic logic [DATA_W-1:0] strb_merge(input logic [DATA_W-1:0] old_val,
                                                   input logic [DATA_W-1:0] new_val,
                                                   input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_val;
    for (int i = 0; i < STRB_W; i++)
    begin
      if (strb[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  assign awready = ~aw_set;
  assign wready  = ~w_set;
  assign bvalid  = (wr_state == WR_RESP);
  assign bresp   = wr_resp;
  assign cfg     = regs_q;

  // Second of the two channels arriving, or both at once
  assign wr_go = (wr_state == WR_COLLECT) && (aw_set || awvalid) && (w_set || wvalid);

  always_ff @(posedge aclk)
  begin
    if (!areset_n)
    begin
      aw_set   <= 1'b0;
      w_set    <= 1'b0;
      wr_req   <= 1'b0;
      wr_state <= WR_COLLECT;
    end
    else
    begin
      wr_req <= 1'b0;
      case (wr_state)
        WR_COLLECT:
        begin
          if (awvalid && !aw_set)
            aw_set <= 1'b1;
          if (wvalid && !w_set)
            w_set <= 1'b1;
          if (wr_go)
          begin
            wr_req   <= 1'b1;
            wr_state <= WR_COMMIT;
          end
        end
        WR_COMMIT:
        begin
          // Register loads on the same edge
          if (wr_req_d0)
            wr_state <= WR_RESP;
        end
        WR_RESP:
        begin
          if (bready)
          begin
            aw_set   <= 1'b0;
            w_set    <= 1'b0;
            wr_state <= WR_COLLECT;
          end
        end
        default:
          wr_state <= WR_COLLECT;
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (awvalid && awready)
      wr_addr <= awaddr;
    if (wvalid && wready)
    begin
      wr_data <= wdata;
      wr_strb <= wstrb;
    end
    wr_adr_d0  <= wr_addr;
    wr_dat_d0  <= wr_data;
    wr_strb_d0 <= wr_strb;
    if (wr_req_d0)
      wr_resp <= wr_aligned ? OKAY : SLVERR;
  end

  // Pipeline stage between capture and register update
  always_ff @(posedge aclk)
  begin
    if (!areset_n)
      wr_req_d0 <= 1'b0;
    else
      wr_req_d0 <= wr_req;
  end

  assign wr_aligned = (wr_adr_d0[1:0] == 2'b00);

  always_ff @(posedge aclk)
  begin
    if (!areset_n)
      regs_q <= '0;
    else if (wr_req_d0 && wr_aligned)
    begin
      case (wr_adr_d0)
        REG_PERIOD_ADDR:
          regs_q.period <= strb_merge(regs_q.period, wr_dat_d0, wr_strb_d0);
        REG_DUTY_ADDR:
          regs_q.duty <= strb_merge(regs_q.duty, wr_dat_d0, wr_strb_d0);
        default:
          regs_q <= regs_q;
      endcase
    end
  end

  assign arready = (rd_state == RD_IDLE);
  assign rvalid  = (rd_state == RD_RESP);

  always_ff @(posedge aclk)
  begin
    if (!areset_n)
    begin
      rd_req   <= 1'b0;
      rd_ack   <= 1'b0;
      rd_state <= RD_IDLE;
    end
    else
    begin
      rd_req <= 1'b0;
      rd_ack <= rd_req;
      case (rd_state)
        RD_IDLE:
        begin
          if (arvalid)
          begin
            rd_req   <= 1'b1;
            rd_state <= RD_FETCH;
          end
        end
        RD_FETCH:
        begin
          if (rd_ack)
            rd_state <= RD_RESP;
        end
        RD_RESP:
        begin
          if (rready)
            rd_state <= RD_IDLE;
        end
        default:
          rd_state <= RD_IDLE;
      endcase
    end
  end

  // Misaligned reads return zero
  always_comb
  begin
    rd_sel = '0;
    if (rd_addr[1:0] == 2'b00)
    begin
      case (rd_addr)
        REG_PERIOD_ADDR: rd_sel = regs_q.period;
        REG_DUTY_ADDR:   rd_sel = regs_q.duty;
        default:         rd_sel = '0;
      endcase
    end
  end

  always_ff @(posedge aclk)
  begin
    if (arvalid && arready)
      rd_addr <= araddr;
    if (rd_req)
    begin
      rd_dat_q  <= rd_sel;
      rd_resp_q <= (rd_addr[1:0] == 2'b00) ? OKAY : SLVERR;
    end
    if (rd_ack)
    begin
      rdata <= rd_dat_q;
      rresp <= rd_resp_q;
    end
  end

endmodule

// File: source/pwm_gen.sv
`timescale 1ns/10ps

module pwm_gen
#(
  parameter int CNT_W = 16
)
(
  input  logic                     aclk,
  input  logic                     areset_n,
  input  pwm_periph_pkg::pwm_cfg_t cfg,
  output logic                     pwm_out
);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] period_c;
  logic [CNT_W-1:0] duty_c;
  logic             cnt_last;

  assign period_c = cfg.period[CNT_W-1:0];
  assign duty_c   = cfg.duty[CNT_W-1:0];

  // Zero period parks the counter at zero
  // Wrap early too when the period shrinks below the current count
  assign cnt_last = (period_c == '0) || (cnt >= period_c - 1'b1);

  always_ff @(posedge aclk)
  begin
    if (!areset_n)
      cnt <= '0;
    else if (cnt_last)
      cnt <= '0;
    else
      cnt <= cnt + 1'b1;
  end

  // High for counter values below duty, so one pass gives min(duty, period)
  always_ff @(posedge aclk)
  begin
    if (!areset_n)
      pwm_out <= 1'b0;
    else
      pwm_out <= (cnt < duty_c);
  end

endmodule

// File: source/pwm_periph_pkg.sv
package pwm_periph_pkg;

  // AXI4-Lite bus widths
  localparam int ADDR_W = 3;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Register map in byte addresses
  localparam logic [ADDR_W-1:0] REG_PERIOD_ADDR = 3'd0;
  localparam logic [ADDR_W-1:0] REG_DUTY_ADDR   = 3'd4;

  typedef enum logic [1:0]
  {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_t;

  // Live configuration seen by the PWM generator
  typedef struct packed
  {
    logic [DATA_W-1:0] period;
    logic [DATA_W-1:0] duty;
  } pwm_cfg_t;

  typedef enum logic [1:0]
  {
    WR_COLLECT,
    WR_COMMIT,
    WR_RESP
  } wr_state_t;

  typedef enum logic [1:0]
  {
    RD_IDLE,
    RD_FETCH,
    RD_RESP
  } rd_state_t;

endpackage

// File: source/pwm_periph_top.sv
`timescale 1ns/10ps

module pwm_periph_top
#(
  parameter int CNT_W = 16
)
(
  input  logic                                aclk,
  input  logic                                areset_n,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [pwm_periph_pkg::ADDR_W-1:0]   awaddr,
  input  logic                                wvalid,
  output logic                                wready,
  input  logic [pwm_periph_pkg::DATA_W-1:0]   wdata,
  input  logic [pwm_periph_pkg::STRB_W-1:0]   wstrb,
  output logic                                bvalid,
  input  logic                                bready,
  output pwm_periph_pkg::axi_resp_t           bresp,
  input  logic                                arvalid,
  output logic                                arready,
  input  logic [pwm_periph_pkg::ADDR_W-1:0]   araddr,
  output logic                                rvalid,
  input  logic                                rready,
  output logic [pwm_periph_pkg::DATA_W-1:0]   rdata,
  output pwm_periph_pkg::axi_resp_t           rresp,
  output logic                                pwm_out
);
  import pwm_periph_pkg::*;

  // Register contents straight to the generator
  pwm_cfg_t cfg;

  axil_regs u_regs
  (
    .aclk     (aclk),
    .areset_n (areset_n),
    .awvalid  (awvalid),
    .awready  (awready),
    .awaddr   (awaddr),
    .wvalid   (wvalid),
    .wready   (wready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .bvalid   (bvalid),
    .bready   (bready),
    .bresp    (bresp),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .rdata    (rdata),
    .rresp    (rresp),
    .cfg      (cfg)
  );

  pwm_gen #(.CNT_W(CNT_W)) u_pwm
  (
    .aclk     (aclk),
    .areset_n (areset_n),
    .cfg      (cfg),
    .pwm_out  (pwm_out)
  );

endmodule

// File: sources.f
source/pwm_periph_pkg.sv
source/axil_regs.sv
source/pwm_gen.sv
source/pwm_periph_top.sv
dv/pwm_periph_assert.sv
dv/pwm_periph_tb.sv
